// File: flist.f
rs_pkg.sv
dispatch_decoder.sv
station_entries.sv
alu.sv
writeback_state.sv
rs_top.sv
rs_properties.sv
tb_rs.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_rs -f flist.f \
    && ./obj_dir/Vtb_rs > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
grep -q "^Simulation passed$" sim.log && echo "PASS" || { tail -n 20 sim.log; echo "FAIL"; exit 1; }

// File: tb_rs.sv
module tb_rs;
    timeunit 1ns;
    timeprecision 1ps;
    import rs_pkg::*;

    localparam int NUM_INSTR   = 400;
    localparam int BURST_START = 200; // Issue on every allowed cycle from here on.
    localparam int TAG_COUNT   = 1 << TAG_WIDTH;
    localparam int MAX_CYCLES  = NUM_INSTR * TAG_COUNT + 100;

    logic                      clk_in = 1'b0;
    logic                      rst_in;
    logic                      issue_valid;
    logic [OPCODE_WIDTH-1:0]   issue_op;
    logic [REG_ADDR_WIDTH-1:0] issue_rd;
    logic [REG_ADDR_WIDTH-1:0] issue_rs1;
    logic [REG_ADDR_WIDTH-1:0] issue_rs2;
    logic [XLEN-1:0]           issue_imm;
    logic [TAG_WIDTH-1:0]      issue_tag;
    logic                      free;
    logic                      result_valid;
    logic [REG_ADDR_WIDTH-1:0] result_rd;
    logic [TAG_WIDTH-1:0]      result_tag;
    logic [XLEN-1:0]           result_value;

    integer                    seed;
    logic [31:0]               coin;
    logic [XLEN-1:0]           model_regs [REG_COUNT] = '{default: '0};
    logic [XLEN-1:0]           exp_value [TAG_COUNT];
    logic [REG_ADDR_WIDTH-1:0] exp_rd [TAG_COUNT];
    int                        issue_n [TAG_COUNT] = '{default: 0};
    int                        result_n [TAG_COUNT] = '{default: 0};
    logic [TAG_WIDTH-1:0]      next_tag = '0;
    int                        issued = 0;
    int                        received = 0;
    int                        cycles = 0;
    logic                      free_low_seen = 1'b0;

    rs_top DUT (.*);

    bind rs_top rs_properties props (
        .clk_in, .rst_in, .issue_valid, .issue_tag, .free,
        .result_valid, .result_tag,
        .x0_value (u_writeback.reg_file[0])
    );

    always #4 clk_in = ~clk_in;

    // In-order reference result of one instruction by the RV32I rules.
    function automatic logic [XLEN-1:0] reference_result(input logic [OPCODE_WIDTH-1:0] op,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm);
        logic [XLEN-1:0] s;
        s = (op >= OP_ADDI) ? imm : b;
        case (op)
            OP_ADD, OP_ADDI:   return a + s;
            OP_SUB:            return a - s;
            OP_AND, OP_ANDI:   return a & s;
            OP_OR, OP_ORI:     return a | s;
            OP_XOR, OP_XORI:   return a ^ s;
            OP_SLL, OP_SLLI:   return a << s[SHAMT_WIDTH-1:0];
            OP_SRL, OP_SRLI:   return a >> s[SHAMT_WIDTH-1:0];
            OP_SRA, OP_SRAI:   return $signed(a) >>> s[SHAMT_WIDTH-1:0];
            OP_SLT, OP_SLTI:   return {{(XLEN-1){1'b0}}, $signed(a) < $signed(s)};
            OP_SLTU, OP_SLTIU: return {{(XLEN-1){1'b0}}, a < s};
            default:           return imm; // LUI.
        endcase
    endfunction

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [XLEN-1:0] expected, actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic compare_rd(input string name, input logic [REG_ADDR_WIDTH-1:0] expected, actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected x%0d, actual x%0d", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic issue_random();
        logic [31:0] r_op;
        logic [31:0] r_reg;
        logic [31:0] r_imm;
        r_op  = $random(seed);
        r_reg = $random(seed);
        r_imm = $random(seed);
        issue_op  = OPCODE_WIDTH'(r_op % 32'd20);
        // Three in four register draws land in x0 to x7.
        issue_rd  = (r_reg[1:0] != 2'b00) ? {2'b00, r_reg[4:2]} : r_reg[9:5];
        issue_rs1 = (r_reg[11:10] != 2'b00) ? {2'b00, r_reg[14:12]} : r_reg[19:15];
        issue_rs2 = (r_reg[21:20] != 2'b00) ? {2'b00, r_reg[24:22]} : r_reg[29:25];
        if (issue_op == OP_LUI) begin
            issue_imm = {r_imm[31:12], 12'h000};
        end else if (issue_op >= OP_ADDI) begin
            issue_imm = {{20{r_imm[11]}}, r_imm[11:0]};
        end else begin
            issue_imm = r_imm; // Ignored by the register forms.
        end
        exp_value[next_tag] = reference_result(issue_op, model_regs[issue_rs1],
                                               model_regs[issue_rs2], issue_imm);
        exp_rd[next_tag]    = issue_rd;
        if (issue_rd != '0) begin
            model_regs[issue_rd] = exp_value[next_tag];
        end
        issue_n[next_tag] = issue_n[next_tag] + 1;
        issue_tag   = next_tag;
        issue_valid = 1'b1;
        next_tag    = next_tag + TAG_WIDTH'(1);
        issued      = issued + 1;
    endtask

    // ##############################
    // Result checks and run limit
    // ##############################
    always @(posedge clk_in) begin
        cycles = cycles + 1;
        if (!rst_in && !free) begin
            free_low_seen = 1'b1;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d results never arrived",
                     cycles, NUM_INSTR - received);
            report_failure();
        end else if (!rst_in && result_valid) begin
            if (issue_n[result_tag] == result_n[result_tag]) begin
                $display("Result with tag %0d arrived while no instruction held that tag",
                         result_tag);
                report_failure();
            end else begin
                compare_rd($sformatf("tag %0d rd", result_tag), exp_rd[result_tag], result_rd);
                compare_value($sformatf("tag %0d value", result_tag), exp_value[result_tag],
                              result_value);
                result_n[result_tag] = result_n[result_tag] + 1;
                received = received + 1;
            end
        end
    end

    initial begin
        seed        = 75351;
        rst_in      = 1'b1;
        issue_valid = 1'b0;
        issue_op    = '0;
        issue_rd    = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_imm   = '0;
        issue_tag   = '0;
        repeat (4) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        if (!free) begin
            $display("free is low right after reset");
            report_failure();
        end
        while (issued < NUM_INSTR) begin
            @(posedge clk_in);
            #1;
            issue_valid = 1'b0;
            coin        = $random(seed);
            // A tag is reused only once its last result is back.
            if (free && issue_n[next_tag] == result_n[next_tag]
                    && (coin[0] || issued >= BURST_START)) begin
                issue_random();
            end
        end
        @(posedge clk_in);
        #1;
        issue_valid = 1'b0;
        while (received < NUM_INSTR) begin
            @(posedge clk_in);
            #1;
        end
        if (free_low_seen) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("The station never filled up, free stayed high for the whole run");
            report_failure();
        end
    end

endmodule

// File: rs_properties.sv
module rs_properties (
    input logic                              clk_in,
    input logic                              rst_in,
    input logic                              issue_valid,
    input logic [rs_pkg::TAG_WIDTH-1:0]      issue_tag,
    input logic                              free,
    input logic                              result_valid,
    input logic [rs_pkg::TAG_WIDTH-1:0]      result_tag,
    input logic [rs_pkg::XLEN-1:0]           x0_value
);
    timeunit 1ns;
    timeprecision 1ps;

    // ##############################
    // Reset and issue side
    // ##############################
    quiet_in_reset: assert property (@(posedge clk_in) rst_in |-> !result_valid)
        else $error("result_valid high while reset is asserted");

    no_issue_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
        !free |-> !issue_valid)
        else $error("issue_valid high while the station has no free entry");

    // ##############################
    // Results
    // ##############################
    // Station, ALU and broadcast register take three cycles at least.
    min_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        result_valid |-> !($past(issue_valid) && $past(issue_tag) == result_tag)
                      && !($past(issue_valid, 2) && $past(issue_tag, 2) == result_tag))
        else $error("tag %0d broadcast less than three cycles after its issue", result_tag);

    x0_stays_zero: assert property (@(posedge clk_in) disable iff (rst_in)
        x0_value == '0)
        else $error("register x0 was written with a nonzero value");

endmodule

// File: rs_top.sv
module rs_top (
    input  logic                              clk_in,
    input  logic                              rst_in,
    input  logic                              issue_valid,
    input  logic [rs_pkg::OPCODE_WIDTH-1:0]   issue_op,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] issue_rd,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] issue_rs1,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] issue_rs2,
    input  logic [rs_pkg::XLEN-1:0]           issue_imm,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      issue_tag,
    output logic                              free,
    output logic                              result_valid,
    output logic [rs_pkg::REG_ADDR_WIDTH-1:0] result_rd,
    output logic [rs_pkg::TAG_WIDTH-1:0]      result_tag,
    output logic [rs_pkg::XLEN-1:0]           result_value
);
    import rs_pkg::*;

    logic [REG_ADDR_WIDTH-1:0] lookup_rs1;
    logic [REG_ADDR_WIDTH-1:0] lookup_rs2;
    logic                      rs1_ready;
    logic                      rs2_ready;
    operand_u                  rs1_operand;
    operand_u                  rs2_operand;
    logic                      rename_valid;
    logic [REG_ADDR_WIDTH-1:0] rename_rd;
    logic [TAG_WIDTH-1:0]      rename_tag;

    logic                      alloc_valid;
    logic [ALU_OP_WIDTH-1:0]   alloc_alu_op;
    logic [REG_ADDR_WIDTH-1:0] alloc_rd;
    logic [TAG_WIDTH-1:0]      alloc_tag;
    logic                      alloc_j_ready;
    logic                      alloc_k_ready;
    operand_u                  alloc_j;
    operand_u                  alloc_k;

    logic                      exec_valid;
    logic [ALU_OP_WIDTH-1:0]   exec_alu_op;
    logic [XLEN-1:0]           exec_a;
    logic [XLEN-1:0]           exec_b;
    logic [REG_ADDR_WIDTH-1:0] exec_rd;
    logic [TAG_WIDTH-1:0]      exec_tag;

    logic                      done_valid;
    logic [REG_ADDR_WIDTH-1:0] done_rd;
    logic [TAG_WIDTH-1:0]      done_tag;
    logic [XLEN-1:0]           done_value;

    dispatch_decoder u_decoder (.*);

    station_entries u_station (
        .clk_in, .rst_in,
        .alloc_valid, .alloc_alu_op, .alloc_rd, .alloc_tag,
        .alloc_j_ready, .alloc_j, .alloc_k_ready, .alloc_k,
        .bcast_valid (result_valid),
        .bcast_tag   (result_tag),
        .bcast_value (result_value),
        .free,
        .exec_valid, .exec_alu_op, .exec_a, .exec_b, .exec_rd, .exec_tag
    );

    alu u_alu (.*);

    // The broadcast is the result output.
    writeback_state u_writeback (
        .clk_in, .rst_in,
        .done_valid, .done_rd, .done_tag, .done_value,
        .lookup_rs1, .lookup_rs2,
        .rename_valid, .rename_rd, .rename_tag,
        .bcast_valid (result_valid),
        .bcast_rd    (result_rd),
        .bcast_tag   (result_tag),
        .bcast_value (result_value),
        .rs1_ready, .rs1_operand, .rs2_ready, .rs2_operand
    );

endmodule

// File: writeback_state.sv
module writeback_state (
    input  logic                              clk_in,
    input  logic                              rst_in,
    input  logic                              done_valid,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] done_rd,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      done_tag,
    input  logic [rs_pkg::XLEN-1:0]           done_value,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] lookup_rs1,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] lookup_rs2,
    input  logic                              rename_valid,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] rename_rd,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      rename_tag,
    output logic                              bcast_valid,
    output logic [rs_pkg::REG_ADDR_WIDTH-1:0] bcast_rd,
    output logic [rs_pkg::TAG_WIDTH-1:0]      bcast_tag,
    output logic [rs_pkg::XLEN-1:0]           bcast_value,
    output logic                              rs1_ready,
    output rs_pkg::operand_u                  rs1_operand,
    output logic                              rs2_ready,
    output rs_pkg::operand_u                  rs2_operand
);
    import rs_pkg::*;

    logic [XLEN-1:0]      reg_file [REG_COUNT];
    logic [REG_COUNT-1:0] ren_busy;
    logic [TAG_WIDTH-1:0] ren_tag [REG_COUNT];
    logic                 latest;

    // Ready flag on top of the operand word.
    function automatic logic [XLEN:0] lookup(input logic [REG_ADDR_WIDTH-1:0] addr);
        operand_u op;
        logic     rdy;
        op.value = reg_file[addr];
        rdy      = 1'b1;
        if (addr == '0) begin
            op.value = '0;
        end else if (ren_busy[addr] && bcast_valid && ren_tag[addr] == bcast_tag) begin
            op.value = bcast_value; // Same-cycle bypass.
        end else if (ren_busy[addr]) begin
            op.pending.fill = '0;
            op.pending.tag  = ren_tag[addr];
            rdy             = 1'b0;
        end
        return {rdy, op};
    endfunction

    always_comb begin
        {rs1_ready, rs1_operand} = lookup(lookup_rs1);
        {rs2_ready, rs2_operand} = lookup(lookup_rs2);
    end

    // An older producer must not overwrite a renamed register.
    assign latest = bcast_valid && ren_busy[bcast_rd] && ren_tag[bcast_rd] == bcast_tag;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            bcast_valid <= 1'b0;
            ren_busy    <= '0;
            for (int i = 0; i < REG_COUNT; i++) begin
                reg_file[i] <= '0;
            end
        end else begin
            bcast_valid <= done_valid;
            if (latest) begin
                reg_file[bcast_rd] <= bcast_value;
                ren_busy[bcast_rd] <= 1'b0;
            end
            if (rename_valid) begin
                ren_busy[rename_rd] <= 1'b1; // Wins over the clear above.
            end
        end
    end

    always_ff @(posedge clk_in) begin
        bcast_rd    <= done_rd;
        bcast_tag   <= done_tag;
        bcast_value <= done_value;
        if (rename_valid) begin
            ren_tag[rename_rd] <= rename_tag;
        end
    end

endmodule

// File: alu.sv
module alu (
    input  logic                              clk_in,
    input  logic                              rst_in,
    input  logic                              exec_valid,
    input  logic [rs_pkg::ALU_OP_WIDTH-1:0]   exec_alu_op,
    input  logic [rs_pkg::XLEN-1:0]           exec_a,
    input  logic [rs_pkg::XLEN-1:0]           exec_b,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] exec_rd,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      exec_tag,
    output logic                              done_valid,
    output logic [rs_pkg::REG_ADDR_WIDTH-1:0] done_rd,
    output logic [rs_pkg::TAG_WIDTH-1:0]      done_tag,
    output logic [rs_pkg::XLEN-1:0]           done_value
);
    import rs_pkg::*;

    logic [SHAMT_WIDTH-1:0] shamt;
    logic [XLEN-1:0]        result;

    assign shamt = exec_b[SHAMT_WIDTH-1:0];

    always_comb begin
        case (exec_alu_op)
            ALU_SUB:  result = exec_a - exec_b;
            ALU_AND:  result = exec_a & exec_b;
            ALU_OR:   result = exec_a | exec_b;
            ALU_XOR:  result = exec_a ^ exec_b;
            ALU_SLL:  result = exec_a << shamt;
            ALU_SRL:  result = exec_a >> shamt;
            ALU_SRA:  result = $signed(exec_a) >>> shamt;
            ALU_SLT:  result = XLEN'($signed(exec_a) < $signed(exec_b));
            ALU_SLTU: result = XLEN'(exec_a < exec_b);
            default:  result = exec_a + exec_b; // ALU_ADD.
        endcase
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            done_valid <= 1'b0;
        end else begin
            done_valid <= exec_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        done_rd    <= exec_rd;
        done_tag   <= exec_tag;
        done_value <= result;
    end

endmodule

// File: station_entries.sv
module station_entries (
    input  logic                              clk_in,
    input  logic                              rst_in,
    input  logic                              alloc_valid,
    input  logic [rs_pkg::ALU_OP_WIDTH-1:0]   alloc_alu_op,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] alloc_rd,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      alloc_tag,
    input  logic                              alloc_j_ready,
    input  rs_pkg::operand_u                  alloc_j,
    input  logic                              alloc_k_ready,
    input  rs_pkg::operand_u                  alloc_k,
    input  logic                              bcast_valid,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      bcast_tag,
    input  logic [rs_pkg::XLEN-1:0]           bcast_value,
    output logic                              free,
    output logic                              exec_valid,
    output logic [rs_pkg::ALU_OP_WIDTH-1:0]   exec_alu_op,
    output logic [rs_pkg::XLEN-1:0]           exec_a,
    output logic [rs_pkg::XLEN-1:0]           exec_b,
    output logic [rs_pkg::REG_ADDR_WIDTH-1:0] exec_rd,
    output logic [rs_pkg::TAG_WIDTH-1:0]      exec_tag
);
    import rs_pkg::*;

    logic [RS_SIZE-1:0]        busy;
    logic [ALU_OP_WIDTH-1:0]   ent_op [RS_SIZE];
    logic [REG_ADDR_WIDTH-1:0] ent_rd [RS_SIZE];
    logic [TAG_WIDTH-1:0]      ent_tag [RS_SIZE];
    logic [RS_SIZE-1:0]        j_rdy;
    logic [RS_SIZE-1:0]        k_rdy;
    operand_u                  j_op [RS_SIZE];
    operand_u                  k_op [RS_SIZE];

    logic                      sel_found;
    logic [RS_INDEX_WIDTH-1:0] sel_idx;
    logic                      alloc_found;
    logic [RS_INDEX_WIDTH-1:0] alloc_idx;
    logic                      alloc_take;
    logic [RS_INDEX_WIDTH:0]   busy_count;
    logic [RS_INDEX_WIDTH:0]   next_count;

    // ##############################
    // Allocation and selection
    // ##############################
    always_comb begin
        sel_found   = 1'b0;
        sel_idx     = '0;
        alloc_found = 1'b0;
        alloc_idx   = '0;
        busy_count  = '0;
        // Walking down leaves the lowest index in place.
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (busy[i] && j_rdy[i] && k_rdy[i]) begin
                sel_found = 1'b1;
                sel_idx   = RS_INDEX_WIDTH'(i);
            end
            if (!busy[i]) begin
                alloc_found = 1'b1;
                alloc_idx   = RS_INDEX_WIDTH'(i);
            end
            busy_count = busy_count + (RS_INDEX_WIDTH + 1)'(busy[i]);
        end
    end

    assign alloc_take = alloc_valid && alloc_found;
    assign next_count = busy_count + (RS_INDEX_WIDTH + 1)'(alloc_take)
                        - (RS_INDEX_WIDTH + 1)'(sel_found);

    assign exec_valid  = sel_found;
    assign exec_alu_op = ent_op[sel_idx];
    assign exec_a      = j_op[sel_idx].value;
    assign exec_b      = k_op[sel_idx].value;
    assign exec_rd     = ent_rd[sel_idx];
    assign exec_tag    = ent_tag[sel_idx];

    // ##############################
    // Entry state
    // ##############################
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            busy <= '0;
            free <= 1'b1;
        end else begin
            if (sel_found) begin
                busy[sel_idx] <= 1'b0; // Sent entry leaves now.
            end
            if (alloc_take) begin
                busy[alloc_idx] <= 1'b1;
            end
            free <= (next_count < (RS_INDEX_WIDTH + 1)'(RS_SIZE));
        end
    end

    always_ff @(posedge clk_in) begin
        if (bcast_valid) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (!j_rdy[i] && j_op[i].pending.tag == bcast_tag) begin
                    j_op[i].value <= bcast_value;
                    j_rdy[i]      <= 1'b1;
                end
                if (!k_rdy[i] && k_op[i].pending.tag == bcast_tag) begin
                    k_op[i].value <= bcast_value;
                    k_rdy[i]      <= 1'b1;
                end
            end
        end
        if (alloc_take) begin
            ent_op[alloc_idx]  <= alloc_alu_op;
            ent_rd[alloc_idx]  <= alloc_rd;
            ent_tag[alloc_idx] <= alloc_tag;
            j_rdy[alloc_idx]   <= alloc_j_ready;
            j_op[alloc_idx]    <= alloc_j;
            k_rdy[alloc_idx]   <= alloc_k_ready;
            k_op[alloc_idx]    <= alloc_k;
        end
    end

endmodule

// File: dispatch_decoder.sv
module dispatch_decoder (
    input  logic                              issue_valid,
    input  logic [rs_pkg::OPCODE_WIDTH-1:0]   issue_op,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] issue_rd,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] issue_rs1,
    input  logic [rs_pkg::REG_ADDR_WIDTH-1:0] issue_rs2,
    input  logic [rs_pkg::XLEN-1:0]           issue_imm,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      issue_tag,
    input  logic                              rs1_ready,
    input  rs_pkg::operand_u                  rs1_operand,
    input  logic                              rs2_ready,
    input  rs_pkg::operand_u                  rs2_operand,
    output logic [rs_pkg::REG_ADDR_WIDTH-1:0] lookup_rs1,
    output logic [rs_pkg::REG_ADDR_WIDTH-1:0] lookup_rs2,
    output logic                              rename_valid,
    output logic [rs_pkg::REG_ADDR_WIDTH-1:0] rename_rd,
    output logic [rs_pkg::TAG_WIDTH-1:0]      rename_tag,
    output logic                              alloc_valid,
    output logic [rs_pkg::ALU_OP_WIDTH-1:0]   alloc_alu_op,
    output logic [rs_pkg::REG_ADDR_WIDTH-1:0] alloc_rd,
    output logic [rs_pkg::TAG_WIDTH-1:0]      alloc_tag,
    output logic                              alloc_j_ready,
    output rs_pkg::operand_u                  alloc_j,
    output logic                              alloc_k_ready,
    output rs_pkg::operand_u                  alloc_k
);
    import rs_pkg::*;

    logic use_rs1;
    logic use_rs2;

    assign use_rs1 = (issue_op != OP_LUI);
    assign use_rs2 = (issue_op < OP_ADDI); // Immediate forms sit above the register forms.

    assign lookup_rs1 = issue_rs1;
    assign lookup_rs2 = issue_rs2;

    // Only real destinations enter the rename table.
    assign rename_valid = issue_valid && (issue_rd != '0);
    assign rename_rd    = issue_rd;
    assign rename_tag   = issue_tag;

    assign alloc_valid = issue_valid;
    assign alloc_rd    = issue_rd;
    assign alloc_tag   = issue_tag;

    always_comb begin
        case (issue_op)
            OP_ADD, OP_ADDI, OP_LUI: alloc_alu_op = ALU_ADD;
            OP_SUB:                  alloc_alu_op = ALU_SUB;
            OP_AND, OP_ANDI:         alloc_alu_op = ALU_AND;
            OP_OR, OP_ORI:           alloc_alu_op = ALU_OR;
            OP_XOR, OP_XORI:         alloc_alu_op = ALU_XOR;
            OP_SLL, OP_SLLI:         alloc_alu_op = ALU_SLL;
            OP_SRL, OP_SRLI:         alloc_alu_op = ALU_SRL;
            OP_SRA, OP_SRAI:         alloc_alu_op = ALU_SRA;
            OP_SLT, OP_SLTI:         alloc_alu_op = ALU_SLT;
            OP_SLTU, OP_SLTIU:       alloc_alu_op = ALU_SLTU;
            default:                 alloc_alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        // LUI adds the immediate to zero.
        alloc_j_ready = 1'b1;
        alloc_j.value = '0;
        if (use_rs1) begin
            alloc_j_ready = rs1_ready;
            alloc_j       = rs1_operand;
        end
        alloc_k_ready = 1'b1;
        alloc_k.value = issue_imm;
        if (use_rs2) begin
            alloc_k_ready = rs2_ready;
            alloc_k       = rs2_operand;
        end
    end

endmodule

// File: rs_pkg.sv
package rs_pkg;

    // ##############################
    // Widths and sizes
    // ##############################
    localparam int XLEN           = 32;
    localparam int REG_COUNT      = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int TAG_WIDTH      = 4;
    localparam int RS_SIZE        = 4;
    localparam int RS_INDEX_WIDTH = 2;
    localparam int OPCODE_WIDTH   = 6;
    localparam int ALU_OP_WIDTH   = 4;
    localparam int SHAMT_WIDTH    = 5;

    // ##############################
    // Issue opcodes
    // ##############################
    localparam logic [OPCODE_WIDTH-1:0] OP_ADD   = 6'd0;
    localparam logic [OPCODE_WIDTH-1:0] OP_SUB   = 6'd1;
    localparam logic [OPCODE_WIDTH-1:0] OP_AND   = 6'd2;
    localparam logic [OPCODE_WIDTH-1:0] OP_OR    = 6'd3;
    localparam logic [OPCODE_WIDTH-1:0] OP_XOR   = 6'd4;
    localparam logic [OPCODE_WIDTH-1:0] OP_SLL   = 6'd5;
    localparam logic [OPCODE_WIDTH-1:0] OP_SRL   = 6'd6;
    localparam logic [OPCODE_WIDTH-1:0] OP_SRA   = 6'd7;
    localparam logic [OPCODE_WIDTH-1:0] OP_SLT   = 6'd8;
    localparam logic [OPCODE_WIDTH-1:0] OP_SLTU  = 6'd9;
    localparam logic [OPCODE_WIDTH-1:0] OP_ADDI  = 6'd10; // First immediate form.
    localparam logic [OPCODE_WIDTH-1:0] OP_ANDI  = 6'd11;
    localparam logic [OPCODE_WIDTH-1:0] OP_ORI   = 6'd12;
    localparam logic [OPCODE_WIDTH-1:0] OP_XORI  = 6'd13;
    localparam logic [OPCODE_WIDTH-1:0] OP_SLLI  = 6'd14;
    localparam logic [OPCODE_WIDTH-1:0] OP_SRLI  = 6'd15;
    localparam logic [OPCODE_WIDTH-1:0] OP_SRAI  = 6'd16;
    localparam logic [OPCODE_WIDTH-1:0] OP_SLTI  = 6'd17;
    localparam logic [OPCODE_WIDTH-1:0] OP_SLTIU = 6'd18;
    localparam logic [OPCODE_WIDTH-1:0] OP_LUI   = 6'd19;

    // ##############################
    // ALU codes
    // ##############################
    localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL  = 4'd5;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLT  = 4'd8;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTU = 4'd9;

    // A source slot holds either its value or the tag of its producer.
    typedef union packed {
        logic [XLEN-1:0] value;
        struct packed {
            logic [XLEN-TAG_WIDTH-1:0] fill;
            logic [TAG_WIDTH-1:0]      tag;
        } pending;
    } operand_u;

endpackage
